/* design/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

`default_nettype none

// ram depth in 32-bit words
`define MEM_WORDS 1024
`define MEM_BYTES (`MEM_WORDS * 4)

// core clock in MHz, also the mtime prescale
`define CLK_MHZ 27

// address map
`define RAM_BASE   32'h0000_0000
`define TIMER_BASE 32'h4000_0000

`default_nettype wire

`endif

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [63:0] dword_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // which requester an issued memory request belongs to
    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } mem_src_e;

    // byte lanes touched by an access at offset zero
    function automatic strb_t size_mask(access_size_e size);
        strb_t mask;
        case (size)
            SIZE_BYTE: mask = 4'b0001;
            SIZE_HALF: mask = 4'b0011;
            default:   mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

`default_nettype wire

/* design/mem_port_if.sv */
`default_nettype none

interface mem_port_if
    import mem_pkg::*;
();

    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;
    logic  req_wen;
    strb_t req_strb;
    word_t req_wdata;
    logic  resp_valid;
    word_t resp_rdata;

    modport requester (
        output req_valid, req_addr, req_wen, req_strb, req_wdata,
        input  req_ready, resp_valid, resp_rdata
    );

    modport memory (
        input  req_valid, req_addr, req_wen, req_strb, req_wdata,
        output req_ready, resp_valid, resp_rdata
    );

endinterface

`default_nettype wire

/* design/mem_cmd_ctrl.sv */
`default_nettype none

module mem_cmd_ctrl
    import mem_pkg::*;
(
    input  logic          clkConstrained,
    input  logic          arst_n,
    input  logic          exit,
    input  logic          instr_req_valid,
    input  addr_t         instr_req_addr,
    output logic          instr_req_ready,
    output logic          instr_resp_valid,
    output word_t         instr_resp_data,
    mem_port_if.memory    split,
    mem_port_if.requester mem
);

    logic     exited;
    logic     fetch_block;
    logic     instr_want;
    logic     data_want;
    logic     prio_data;
    mem_src_e sel;
    logic     grant_instr;
    logic     grant_data;
    mem_src_e src_q;

    // sticky once the core has signalled exit
    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            exited <= 1'b0;
        end else if (exit) begin
            exited <= 1'b1;
        end
    end

    assign fetch_block = exited | exit;
    assign instr_want  = instr_req_valid & ~fetch_block;
    assign data_want   = split.req_valid;

    // data goes first when alone or when it holds the turn
    assign sel = (data_want && (!instr_want || prio_data)) ? SRC_DATA : SRC_INSTR;

    assign instr_req_ready = mem.req_ready & ~fetch_block & ~(data_want & prio_data);
    assign split.req_ready = mem.req_ready & ~(instr_want & ~prio_data);

    assign grant_instr = instr_want & instr_req_ready;
    assign grant_data  = data_want & split.req_ready;

    // forward the selected request in the same cycle
    assign mem.req_valid = instr_want | data_want;
    assign mem.req_addr  = (sel == SRC_DATA) ? split.req_addr : instr_req_addr;
    assign mem.req_wen   = (sel == SRC_DATA) & split.req_wen;
    assign mem.req_strb  = (sel == SRC_DATA) ? split.req_strb : 4'b1111;
    assign mem.req_wdata = split.req_wdata;

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            prio_data <= 1'b0;
            src_q     <= SRC_INSTR;
        end else if (grant_instr || grant_data) begin
            src_q <= sel;
            // hand the turn to the loser under contention
            if (instr_want && data_want) begin
                prio_data <= (sel == SRC_INSTR);
            end
        end
    end

    // memory answers one cycle later, so the last tag names the owner
    assign instr_resp_valid = mem.resp_valid & (src_q == SRC_INSTR);
    assign instr_resp_data  = mem.resp_rdata;
    assign split.resp_valid = mem.resp_valid & (src_q == SRC_DATA);
    assign split.resp_rdata = mem.resp_rdata;

endmodule

`default_nettype wire

/* design/unaligned_access.sv */
`default_nettype none

module unaligned_access
    import mem_pkg::*;
(
    input  logic          clkConstrained,
    input  logic          arst_n,
    input  logic          req_valid,
    input  addr_t         req_addr,
    input  logic          req_wen,
    input  access_size_e  req_size,
    input  word_t         req_wdata,
    output logic          req_ready,
    output logic          resp_valid,
    output word_t         resp_rdata,
    mem_port_if.requester split
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SECOND,
        ST_WAIT
    } state_e;

    state_e       state;
    logic [1:0]   offset;
    logic [7:0]   lane_mask;
    logic [63:0]  lane_wdata;
    logic         crossing;
    addr_t        word_addr;
    logic         issue;
    logic [1:0]   pend_cnt;
    logic [1:0]   off_q;
    access_size_e size_q;
    word_t        hold_q;
    logic         have_first;
    logic [63:0]  merged;
    logic [63:0]  merged_sh;

    // lanes over two words, upper half is the next word
    assign offset     = req_addr[1:0];
    assign lane_mask  = {4'b0000, size_mask(req_size)} << offset;
    assign lane_wdata = {32'h0, req_wdata} << {offset, 3'b000};
    assign crossing   = |lane_mask[7:4];
    assign word_addr  = {req_addr[31:2], 2'b00};

    always_comb begin
        split.req_addr  = word_addr;
        split.req_wen   = req_wen;
        split.req_strb  = lane_mask[3:0];
        split.req_wdata = lane_wdata[31:0];
        split.req_valid = 1'b0;
        req_ready       = 1'b0;
        case (state)
            ST_IDLE: begin
                // let older responses drain so the two halves pair up
                split.req_valid = req_valid && (!crossing || pend_cnt == 2'd0);
                req_ready       = split.req_ready && !crossing;
            end
            ST_SECOND: begin
                split.req_addr  = word_addr + 32'd4;
                split.req_strb  = lane_mask[7:4];
                split.req_wdata = lane_wdata[63:32];
                split.req_valid = 1'b1;
                req_ready       = split.req_ready;
            end
            default: begin
                req_ready = 1'b0;
            end
        endcase
    end

    assign issue = split.req_valid & split.req_ready;

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            pend_cnt   <= 2'd0;
            have_first <= 1'b0;
        end else begin
            pend_cnt <= pend_cnt + {1'b0, issue} - {1'b0, split.resp_valid};
            case (state)
                ST_IDLE: begin
                    if (issue && crossing) begin
                        state <= ST_SECOND;
                    end
                end
                ST_SECOND: begin
                    if (issue) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (have_first && split.resp_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            // first half sets it, second half clears it
            if (split.resp_valid && state != ST_IDLE) begin
                have_first <= !have_first;
            end
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (issue && state == ST_IDLE) begin
            off_q  <= offset;
            size_q <= req_size;
        end
        if (split.resp_valid && state != ST_IDLE && !have_first) begin
            hold_q <= split.resp_rdata;
        end
    end

    assign merged    = (state == ST_WAIT) ? {split.resp_rdata, hold_q}
                                          : {32'h0, split.resp_rdata};
    assign merged_sh = merged >> {off_q, 3'b000};

    // right aligned, zero extended
    always_comb begin
        case (size_q)
            SIZE_BYTE: resp_rdata = {24'h0, merged_sh[7:0]};
            SIZE_HALF: resp_rdata = {16'h0, merged_sh[15:0]};
            default:   resp_rdata = merged_sh[31:0];
        endcase
    end

    assign resp_valid = split.resp_valid
                        && (state == ST_IDLE || (state == ST_WAIT && have_first));

endmodule

`default_nettype wire

/* design/mem_map.sv */
`include "mem_settings.svh"
`default_nettype none

module mem_map
    import mem_pkg::*;
(
    input  logic       clkConstrained,
    input  logic       arst_n,
    mem_port_if.memory mem,
    input  dword_t     mtime,
    input  dword_t     mtimecmp,
    output logic       cmp_wen,
    output logic       cmp_hi,
    output word_t      cmp_wdata
);

    localparam int    IDX_W        = $clog2(`MEM_WORDS);
    localparam addr_t TIMER_BASE_A = `TIMER_BASE;

    word_t            ram [`MEM_WORDS];
    addr_t            ram_off;
    logic             hit_ram;
    logic             hit_timer;
    logic             fire;
    logic [IDX_W-1:0] ram_idx;
    word_t            timer_rdata;
    word_t            rdata_q;
    logic             resp_q;

    // never stalls
    assign mem.req_ready = 1'b1;
    assign fire          = mem.req_valid & mem.req_ready;

    assign ram_off   = mem.req_addr - `RAM_BASE;
    assign hit_ram   = ram_off < `MEM_BYTES;
    assign hit_timer = mem.req_addr[31:4] == TIMER_BASE_A[31:4];
    assign ram_idx   = ram_off[IDX_W+1:2];

    always_comb begin
        case (mem.req_addr[3:2])
            2'd0:    timer_rdata = mtime[31:0];
            2'd1:    timer_rdata = mtime[63:32];
            2'd2:    timer_rdata = mtimecmp[31:0];
            default: timer_rdata = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge clkConstrained) begin
        if (fire && hit_ram) begin
            rdata_q <= ram[ram_idx];
            if (mem.req_wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem.req_strb[b]) begin
                        ram[ram_idx][8*b +: 8] <= mem.req_wdata[8*b +: 8];
                    end
                end
            end
        end else if (fire) begin
            // unmapped space reads as zero
            rdata_q <= (hit_timer && !mem.req_wen) ? timer_rdata : 32'h0;
        end
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= fire;
        end
    end

    assign mem.resp_valid = resp_q;
    assign mem.resp_rdata = rdata_q;

    // mtimecmp halves at offsets 8 and 12, full word writes only
    assign cmp_wen   = fire & mem.req_wen & hit_timer & mem.req_addr[3];
    assign cmp_hi    = mem.req_addr[2];
    assign cmp_wdata = mem.req_wdata;

endmodule

`default_nettype wire

/* design/time_counter.sv */
`include "mem_settings.svh"
`default_nettype none

module time_counter
    import mem_pkg::*;
(
    input  logic   clkConstrained,
    input  logic   arst_n,
    input  logic   cmp_wen,
    input  logic   cmp_hi,
    input  word_t  cmp_wdata,
    output dword_t cycle,
    output dword_t mtime,
    output dword_t mtimecmp,
    output logic   timer_irq
);

    localparam logic [15:0] PRESC_MAX = 16'(`CLK_MHZ - 1);

    logic [15:0] presc;

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            cycle    <= '0;
            mtime    <= '0;
            presc    <= '0;
            mtimecmp <= '1;
        end else begin
            cycle <= cycle + 64'd1;
            // one mtime tick per microsecond
            if (presc == PRESC_MAX) begin
                presc <= '0;
                mtime <= mtime + 64'd1;
            end else begin
                presc <= presc + 16'd1;
            end
            if (cmp_wen && cmp_hi) begin
                mtimecmp[63:32] <= cmp_wdata;
            end else if (cmp_wen) begin
                mtimecmp[31:0] <= cmp_wdata;
            end
        end
    end

    assign timer_irq = mtime >= mtimecmp;

endmodule

`default_nettype wire

/* design/mem_subsys_top.sv */
`default_nettype none

module mem_subsys_top
    import mem_pkg::*;
(
    input  logic         clkConstrained,
    input  logic         arst_n,
    input  logic         instr_req_valid,
    input  addr_t        instr_req_addr,
    output logic         instr_req_ready,
    output logic         instr_resp_valid,
    output word_t        instr_resp_data,
    input  logic         data_req_valid,
    input  addr_t        data_req_addr,
    input  logic         data_req_wen,
    input  access_size_e data_req_size,
    input  word_t        data_req_wdata,
    output logic         data_req_ready,
    output logic         data_resp_valid,
    output word_t        data_resp_rdata,
    input  logic         exit,
    output dword_t       cycle,
    output dword_t       mtime,
    output logic         timer_irq
);

    dword_t mtimecmp;
    logic   cmp_wen;
    logic   cmp_hi;
    word_t  cmp_wdata;

    mem_port_if split_if ();
    mem_port_if mem_if ();

    unaligned_access i_unaligned_access (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .req_valid      (data_req_valid),
        .req_addr       (data_req_addr),
        .req_wen        (data_req_wen),
        .req_size       (data_req_size),
        .req_wdata      (data_req_wdata),
        .req_ready      (data_req_ready),
        .resp_valid     (data_resp_valid),
        .resp_rdata     (data_resp_rdata),
        .split          (split_if.requester)
    );

    mem_cmd_ctrl i_mem_cmd_ctrl (
        .clkConstrained   (clkConstrained),
        .arst_n           (arst_n),
        .exit             (exit),
        .instr_req_valid  (instr_req_valid),
        .instr_req_addr   (instr_req_addr),
        .instr_req_ready  (instr_req_ready),
        .instr_resp_valid (instr_resp_valid),
        .instr_resp_data  (instr_resp_data),
        .split            (split_if.memory),
        .mem              (mem_if.requester)
    );

    mem_map i_mem_map (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .mem            (mem_if.memory),
        .mtime          (mtime),
        .mtimecmp       (mtimecmp),
        .cmp_wen        (cmp_wen),
        .cmp_hi         (cmp_hi),
        .cmp_wdata      (cmp_wdata)
    );

    time_counter i_time_counter (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .cmp_wen        (cmp_wen),
        .cmp_hi         (cmp_hi),
        .cmp_wdata      (cmp_wdata),
        .cycle          (cycle),
        .mtime          (mtime),
        .mtimecmp       (mtimecmp),
        .timer_irq      (timer_irq)
    );

endmodule

`default_nettype wire

/* bench/mem_subsys_chk.sv */
`default_nettype none

module mem_subsys_chk
    import mem_pkg::*;
(
    input logic     clkConstrained,
    input logic     arst_n,
    input logic     grant_instr,
    input logic     grant_data,
    input logic     exited,
    input mem_src_e src_q,
    input logic     mem_resp_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // one memory port, so one owner per cycle
    single_grant: assert property (
        @(posedge clkConstrained) disable iff (!arst_n)
        !(grant_instr && grant_data)
    ) else begin
        fail_cnt++;
        $error("fetch and data granted in the same cycle");
    end

    // memory answers exactly one cycle after a grant
    resp_after_grant: assert property (
        @(posedge clkConstrained) disable iff (!arst_n)
        mem_resp_valid |-> $past(grant_instr || grant_data)
    ) else begin
        fail_cnt++;
        $error("memory response without a request in the previous cycle");
    end

    // anything issued after exit comes back tagged as data
    no_fetch_after_exit: assert property (
        @(posedge clkConstrained) disable iff (!arst_n)
        exited && (grant_instr || grant_data) |=> mem_resp_valid && src_q == SRC_DATA
    ) else begin
        fail_cnt++;
        $error("request issued after exit was not answered as a data access");
    end

endmodule

`default_nettype wire

/* bench/mem_subsys_tb.sv */
`include "mem_settings.svh"
`default_nettype none

module mem_subsys_tb
    import mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic         clkConstrained = 1'b0;
    logic         arst_n;
    logic         instr_req_valid;
    addr_t        instr_req_addr;
    logic         instr_req_ready;
    logic         instr_resp_valid;
    word_t        instr_resp_data;
    logic         data_req_valid;
    addr_t        data_req_addr;
    logic         data_req_wen;
    access_size_e data_req_size;
    word_t        data_req_wdata;
    logic         data_req_ready;
    logic         data_resp_valid;
    word_t        data_resp_rdata;
    logic         exit;
    dword_t       cycle;
    dword_t       mtime;
    logic         timer_irq;

    byte          op_q[$];
    addr_t        addr_q[$];
    access_size_e size_q[$];
    word_t        wdata_q[$];
    word_t        exp_q[$];
    word_t        data_rq[$];
    word_t        instr_rq[$];
    logic [7:0]   model_mem [`MEM_BYTES];
    int           data_pend = 0;
    int           instr_pend = 0;
    int           errors = 0;
    int           checks = 0;
    int           limit_cycles = 0;
    int unsigned  elapsed = 0;
    word_t        last_mtime = 32'h0;
    logic         exit_seen = 1'b0;
    integer       seed = 18;

    mem_subsys_top i_mem_subsys_top (.*);

    bind mem_cmd_ctrl mem_subsys_chk i_ctrl_chk (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .grant_instr    (grant_instr),
        .grant_data     (grant_data),
        .exited         (exited),
        .src_q          (src_q),
        .mem_resp_valid (mem.resp_valid)
    );

    always #5 clkConstrained = ~clkConstrained;

    always @(posedge clkConstrained) begin
        if (arst_n) begin
            elapsed <= elapsed + 1;
        end
    end

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok === 1'b1) else begin
            errors++;
            $display("Fail %0t: %s", $time, what);
        end
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // little endian byte model of the ram
    function automatic int access_bytes(access_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic logic is_ram_addr(addr_t addr);
        return (addr - `RAM_BASE) < `MEM_BYTES;
    endfunction

    function automatic void store_bytes(addr_t addr, access_size_e size, word_t wdata);
        for (int i = 0; i < access_bytes(size); i++) begin
            if (is_ram_addr(addr + i)) begin
                model_mem[addr + i - `RAM_BASE] = wdata[8*i +: 8];
            end
        end
    endfunction

    function automatic word_t load_bytes(addr_t addr, access_size_e size);
        word_t value;
        value = 32'h0;
        for (int i = 0; i < access_bytes(size); i++) begin
            if (is_ram_addr(addr + i)) begin
                value[8*i +: 8] = model_mem[addr + i - `RAM_BASE];
            end
        end
        return value;
    endfunction

    task automatic load_patterns();
        int    fd;
        int    size;
        string line;
        byte   op;
        addr_t addr;
        word_t wdata;
        word_t expv;
        fd = $fopen("bench/mem_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file bench/mem_patterns.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%c %h %d %h %h", op, addr, size, wdata, expv) == 5) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    size_q.push_back(access_size_e'(size[1:0]));
                    wdata_q.push_back(wdata);
                    exp_q.push_back(expv);
                end
            end
        end
        $fclose(fd);
    endtask

    // drive on the falling edge, ready sampled once it has settled
    task automatic data_access(input logic wen, input addr_t addr, input access_size_e size,
                               input word_t wdata, output word_t rdata);
        logic acc;
        @(negedge clkConstrained);
        data_req_valid = 1'b1;
        data_req_addr  = addr;
        data_req_wen   = wen;
        data_req_size  = size;
        data_req_wdata = wdata;
        do begin
            #1;
            acc = data_req_ready;
            if (acc) begin
                data_pend++;
            end
            @(negedge clkConstrained);
        end while (!acc);
        data_req_valid = 1'b0;
        while (data_rq.size() == 0) begin
            @(posedge clkConstrained);
        end
        rdata = data_rq.pop_front();
    endtask

    task automatic fetch_word(input addr_t addr, output word_t rdata);
        logic acc;
        @(negedge clkConstrained);
        instr_req_valid = 1'b1;
        instr_req_addr  = addr;
        do begin
            #1;
            acc = instr_req_ready;
            if (acc) begin
                instr_pend++;
            end
            @(negedge clkConstrained);
        end while (!acc);
        instr_req_valid = 1'b0;
        while (instr_rq.size() == 0) begin
            @(posedge clkConstrained);
        end
        rdata = instr_rq.pop_front();
    endtask

    // responses are single cycle pulses, caught at the falling edge
    always @(negedge clkConstrained) begin
        if (arst_n) begin
            if (data_resp_valid) begin
                assert (data_pend > 0) else begin
                    errors++;
                    $display("data response at %0t with no data request outstanding", $time);
                end
                data_rq.push_back(data_resp_rdata);
                data_pend--;
            end
            if (instr_resp_valid) begin
                assert (instr_pend > 0) else begin
                    errors++;
                    $display("fetch response at %0t with no fetch outstanding", $time);
                end
                instr_rq.push_back(instr_resp_data);
                instr_pend--;
            end
            if (exit_seen) begin
                assert (instr_req_ready === 1'b0) else begin
                    errors++;
                    $display("instruction port ready again after exit at %0t", $time);
                end
            end
            // one count per clock since reset release
            checks++;
            assert (cycle === dword_t'(elapsed)) else begin
                errors++;
                $display("Fail %0t: cycle %0d, expected %0d", $time, cycle, elapsed);
            end
        end
    end

    task automatic run_pattern(input byte op, input addr_t addr, input access_size_e size,
                               input word_t wdata, input word_t expv);
        word_t got;
        word_t fgot;
        addr_t faddr;
        case (op)
            "W": begin
                data_access(1'b1, addr, size, wdata, got);
                store_bytes(addr, size, wdata);
            end
            "R": begin
                data_access(1'b0, addr, size, 32'h0, got);
                compare_word(got, expv, $sformatf("data read at %h", addr));
                if (is_ram_addr(addr)) begin
                    compare_word(got, load_bytes(addr, size),
                                 $sformatf("data read at %h against model", addr));
                end
            end
            "F": begin
                fetch_word(addr, got);
                compare_word(got, load_bytes(addr, SIZE_WORD), $sformatf("fetch at %h", addr));
            end
            "B": begin
                // background fetch from one of the first four words written
                faddr = ({$random(seed)} % 4) * 4;
                fork
                    data_access(1'b0, addr, size, 32'h0, got);
                    fetch_word(faddr, fgot);
                join
                compare_word(got, expv, $sformatf("contended data read at %h", addr));
                compare_word(fgot, load_bytes(faddr, SIZE_WORD),
                             $sformatf("contended fetch at %h", faddr));
            end
            "T": begin
                data_access(1'b0, `TIMER_BASE, SIZE_WORD, 32'h0, got);
                #1;
                expect_true(got >= last_mtime, $sformatf("mtime went back to %0d", got));
                expect_true(got <= elapsed / `CLK_MHZ + 1,
                            $sformatf("mtime %0d ahead of %0d cycles", got, elapsed));
                // the output may only have moved on since the read
                expect_true(mtime >= got && mtime <= elapsed / `CLK_MHZ + 1,
                            $sformatf("mtime output %0d after read %0d", mtime, got));
                last_mtime = got;
            end
            "C": begin
                data_access(1'b1, `TIMER_BASE + 32'd12, SIZE_WORD, 32'h0, got);
                data_access(1'b1, addr, SIZE_WORD, wdata, got);
                expect_true(timer_irq === expv[0],
                            $sformatf("timer_irq %b after mtimecmp %h", timer_irq, wdata));
            end
            "X": begin
                // fetch stays requested so a stray grant would show
                @(negedge clkConstrained);
                exit            = 1'b1;
                instr_req_valid = 1'b1;
                instr_req_addr  = `RAM_BASE;
                #1;
                exit_seen = 1'b1;
            end
            default: begin
                errors++;
                $display("unknown operation '%c' in the pattern file", op);
            end
        endcase
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clkConstrained);
        $display("timeout, the run did not finish within %0d cycles", limit_cycles);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int total;
        arst_n          = 1'b0;
        instr_req_valid = 1'b0;
        instr_req_addr  = 32'h0;
        data_req_valid  = 1'b0;
        data_req_addr   = 32'h0;
        data_req_wen    = 1'b0;
        data_req_size   = SIZE_WORD;
        data_req_wdata  = 32'h0;
        exit            = 1'b0;
        load_patterns();
        limit_cycles = op_q.size() * 50 + 200;
        repeat (10) @(posedge clkConstrained);
        @(negedge clkConstrained);
        arst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            run_pattern(op_q[i], addr_q[i], size_q[i], wdata_q[i], exp_q[i]);
        end
        repeat (4) @(negedge clkConstrained);
        expect_true(data_pend == 0 && instr_pend == 0, "responses still outstanding at the end");
        total = errors + i_mem_subsys_top.i_mem_cmd_ctrl.i_ctrl_chk.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_mem_subsys_top.i_mem_cmd_ctrl.i_ctrl_chk.fail_cnt);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mem_patterns.txt */
# op addr size wdata expect, hex except size (0 byte, 1 half, 2 word)
# W write, R read, F fetch, B read with fetch, T mtime, C mtimecmp (expect irq), X exit
W 00000000 2 03020100 00000000
W 00000004 2 07060504 00000000
W 00000008 2 0b0a0908 00000000
W 0000000c 2 0f0e0d0c 00000000
W 00000005 0 000000aa 00000000
W 0000000a 1 0000bbcc 00000000
R 00000004 2 00000000 0706aa04
R 00000008 2 00000000 bbcc0908
R 0000000a 1 00000000 0000bbcc
R 00000005 0 00000000 000000aa
W 0000000e 2 44332211 00000000
R 0000000e 2 00000000 44332211
R 0000000c 2 00000000 22110d0c
R 00000003 1 00000000 00000403
W 00000007 1 00005566 00000000
R 00000004 2 00000000 6606aa04
R 00000008 2 00000000 bbcc0955
R 00000007 2 00000000 cc095566
F 0000000c 2 00000000 00000000
B 00000001 1 00000000 00000201
B 0000000f 1 00000000 00003322
W 00001000 2 deadbeef 00000000
R 00001000 2 00000000 00000000
R 00000000 2 00000000 03020100
T 40000000 2 00000000 00000000
C 40000008 2 00000000 00000001
C 40000008 2 ffffffff 00000000
T 40000000 2 00000000 00000000
X 00000000 0 00000000 00000000
W 00000006 1 00001234 00000000
R 00000004 2 00000000 1234aa04
R 00000007 1 00000000 00005512

/* build.f */
+incdir+design
design/mem_pkg.sv
design/mem_port_if.sv
design/mem_cmd_ctrl.sv
design/unaligned_access.sv
design/mem_map.sv
design/time_counter.sv
design/mem_subsys_top.sv
bench/mem_subsys_chk.sv
bench/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/mem_pkg.sv
      - design/mem_port_if.sv
      - design/mem_cmd_ctrl.sv
      - design/unaligned_access.sv
      - design/mem_map.sv
      - design/time_counter.sv
      - design/mem_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/mem_subsys_chk.sv
      - bench/mem_subsys_tb.sv
